// File: dv/tb_regex_engine.sv
// testbench for the regex engine: program table, case table, LFSR strings, check task, timeout
`default_nettype none

module tb_regex_engine;

    timeunit 1ns;
    timeprecision 100ps;

    import regex_pkg::*;

    typedef struct packed {
        logic [2:0] prog;
        window_t    win;
        logic       exp_match;
    } case_t;

    localparam int N_PROGS     = 6;
    localparam int N_DIRECTED  = 12;
    localparam int N_RANDOM    = 12;
    localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * 200;

    logic                clk = 1'b0;
    logic                rst;
    logic                prog_we;
    logic [PC_WIDTH-1:0] prog_addr;
    instr_t              prog_data;
    window_t             window;
    logic                start;
    logic                matched;
    logic                done;

    instr_t              prog_rom [N_PROGS][8];
    int                  prog_len [N_PROGS];
    case_t               cases [$];
    logic [31:0]         lfsr = 32'd97088;
    int                  errors = 0;
    int                  cycles = 0;

    regex_engine DUT (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .window    (window),
        .start     (start),
        .matched   (matched),
        .done      (done)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the engine did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // jumps and splits fill the data field as a target, the rest as a character
    task automatic set_instr(input int p, input int a, input opcode_t op, input logic [7:0] v);
        instr_t i;
        i.opcode = op;
        if (op == JMP || op == SPLIT)
        begin
            i.data.target = v;
        end
        else
        begin
            i.data.ch = v;
        end
        prog_rom[p][a] = i;
        prog_len[p]    = a + 1;
    endtask

    task automatic build_programs();
        // abc exact
        set_instr(0, 0, MATCH, "a");
        set_instr(0, 1, MATCH, "b");
        set_instr(0, 2, MATCH, "c");
        set_instr(0, 3, ACCEPT, 8'h00);
        // a.c
        set_instr(1, 0, MATCH, "a");
        set_instr(1, 1, MATCH_ANY, 8'h00);
        set_instr(1, 2, MATCH, "c");
        set_instr(1, 3, ACCEPT, 8'h00);
        // a(b|c), then the same with a partial accept
        for (int p = 2; p <= 5; p = p + 3)
        begin
            set_instr(p, 0, MATCH, "a");
            set_instr(p, 1, SPLIT, 8'd4);
            set_instr(p, 2, MATCH, "b");
            set_instr(p, 3, JMP, 8'd5);
            set_instr(p, 4, MATCH, "c");
            set_instr(p, 5, (p == 2) ? ACCEPT : ACCEPT_PARTIAL, 8'h00);
        end
        // ab as a prefix
        set_instr(3, 0, MATCH, "a");
        set_instr(3, 1, MATCH, "b");
        set_instr(3, 2, ACCEPT_PARTIAL, 8'h00);
        set_instr(4, 0, END_WITHOUT_ACCEPTING, 8'h00);
    endtask

    // unused window characters are zero terminators
    function automatic window_t make_window(input string s);
        window_t w;
        w = '0;
        for (int i = 0; i < s.len() && i < WINDOW_CHARS; i++)
        begin
            w[i] = s[i];
        end
        return w;
    endfunction

    task automatic add_case(input int p, input window_t w, input logic e);
        case_t c;
        c.prog      = 3'(p);
        c.win       = w;
        c.exp_match = e;
        cases.push_back(c);
    endtask

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [7:0] random_letter();
        logic [1:0] v;
        v[1] = take_bit();
        v[0] = take_bit();
        return 8'h61 + 8'(v % 3);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic write_program(input int p);
        for (int a = 0; a < prog_len[p]; a++)
        begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = PC_WIDTH'(a);
            prog_data = prog_rom[p][a];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic run_case(input int k);
        case_t c;
        int    errs_before;
        c = cases[k];
        errs_before = errors;
        write_program(int'(c.prog));
        window = c.win;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
        while (!done)
        begin
            @(negedge clk);
        end
        check_value("matched", 32'(matched), 32'(c.exp_match));
        $display("case %0d prog %0d window %h expected %0d: %s", k, c.prog, c.win,
                 c.exp_match, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial
    begin
        window_t w;
        logic    e;
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        window    = '0;
        start     = 1'b0;
        build_programs();

        add_case(0, make_window("abc"), 1'b1);
        add_case(0, make_window("abd"), 1'b0);
        add_case(0, make_window("ab"), 1'b0);
        add_case(1, make_window("axc"), 1'b1);
        add_case(1, make_window("abc"), 1'b1);
        add_case(1, make_window("ac"), 1'b0);
        add_case(2, make_window("ab"), 1'b1);
        add_case(2, make_window("ac"), 1'b1);
        add_case(2, make_window("ad"), 1'b0);
        add_case(3, make_window("abz"), 1'b1);
        add_case(3, make_window("az"), 1'b0);
        add_case(4, make_window("abc"), 1'b0);

        // a(b|c) as a prefix: a first, then b or c
        for (int n = 0; n < N_RANDOM; n++)
        begin
            w = '0;
            for (int i = 0; i < 3; i++)
            begin
                w[i] = random_letter();
            end
            e = (w[0] == 8'h61) && (w[1] == 8'h62 || w[1] == 8'h63);
            add_case(5, w, e);
        end

        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("done", 32'(done), 32'd1);

        for (int k = 0; k < cases.size(); k++)
        begin
            run_case(k);
        end

        $display("cases %0d, errors %0d", cases.size(), errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/instr_mem.sv
// program memory with a write port and a one-cycle ready-valid read port
`default_nettype none

module instr_mem (
    input  logic                             clk,

    input  logic                             we,
    input  logic [regex_pkg::PC_WIDTH-1:0]   waddr,
    input  regex_pkg::instr_t                wdata,

    input  logic                             req_valid,
    input  logic [regex_pkg::PC_WIDTH-1:0]   req_addr,
    output logic                             req_ready,
    output regex_pkg::instr_t                rdata
);

    import regex_pkg::*;

    instr_t mem [2**PC_WIDTH];

    // reads never stall
    assign req_ready = 1'b1;

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // rdata holds until the next request
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            rdata <= mem[req_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/regex_cpu_pipelined.sv
// four-stage thread processor with fetch-send, fetch-receive, exe1 and exe2 stages
`default_nettype none

module regex_cpu_pipelined (
    input  logic                             clk,
    input  logic                             rst,
    input  regex_pkg::window_t               window,

    input  logic                             in_valid,
    input  regex_pkg::thread_t               in_thread,
    output logic                             in_ready,

    output logic                             mem_valid,
    output logic [regex_pkg::PC_WIDTH-1:0]   mem_addr,
    input  logic                             mem_ready,
    input  regex_pkg::instr_t                mem_data,

    output logic                             out_valid,
    output regex_pkg::thread_t               out_thread,
    input  logic                             out_ready,

    output logic                             accepts,
    output logic                             running
);

    import regex_pkg::*;

    typedef struct packed {
        thread_t thread;
        instr_t  instr;
    } stage_t;

    // stage state
    logic    fr_valid;
    logic    fr_fresh;
    stage_t  fr;
    logic    ex1_valid;
    stage_t  ex1;
    logic    ex2_valid;
    stage_t  ex2;

    // handshakes between stages
    logic    fs_go;
    logic    fr_go;
    logic    ex1_go;
    logic    ex2_go;
    instr_t  fr_instr_now;

    // exe outputs
    logic    ex1_done;
    logic    ex1_out_valid;
    logic    ex1_out_ready;
    thread_t ex1_out_thread;
    logic    ex1_accepts;
    logic    ex2_out_valid;
    logic    ex2_out_ready;
    thread_t ex2_out_thread;

    assign fr_go  = fr_valid && (!ex1_valid || ex1_go);
    assign ex2_go = ex2_valid && ex2_out_ready;
    assign ex1_go = ex1_valid && (!ex1_out_valid || ex1_out_ready)
                    && (ex1_done || !ex2_valid);

    // fetch-send requests only when fetch-receive can take the thread
    assign mem_valid = in_valid && (!fr_valid || fr_go);
    assign mem_addr  = in_thread.pc;
    assign fs_go     = mem_valid && mem_ready;
    assign in_ready  = fs_go;

    // fetch-receive gets the memory answer one cycle after the request
    assign fr_instr_now = fr_fresh ? mem_data : fr.instr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fr_valid  <= 1'b0;
            fr_fresh  <= 1'b0;
            ex1_valid <= 1'b0;
            ex2_valid <= 1'b0;
        end
        else
        begin
            fr_fresh <= fs_go;
            if (ex2_go)
            begin
                ex2_valid <= 1'b0;
            end
            if (ex1_go)
            begin
                ex1_valid <= 1'b0;
                if (!ex1_done)
                begin
                    ex2_valid <= 1'b1;
                end
            end
            if (fr_go)
            begin
                fr_valid  <= 1'b0;
                ex1_valid <= 1'b1;
            end
            if (fs_go)
            begin
                fr_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        fr.instr <= fr_instr_now;
        if (fs_go)
        begin
            fr.thread <= in_thread;
        end
        if (fr_go)
        begin
            ex1.thread <= fr.thread;
            ex1.instr  <= fr_instr_now;
        end
        if (ex1_go && !ex1_done)
        begin
            ex2 <= ex1;
        end
    end

    // exe1
    always_comb
    begin
        ex1_done             = 1'b1;
        ex1_out_valid        = 1'b0;
        ex1_accepts          = 1'b0;
        ex1_out_thread.pc    = ex1.thread.pc + 1'b1;
        ex1_out_thread.cc_id = ex1.thread.cc_id;
        if (ex1_valid)
        begin
            case (ex1.instr.opcode)
                MATCH:
                begin
                    if (window[ex1.thread.cc_id] == ex1.instr.data.ch)
                    begin
                        ex1_out_valid        = 1'b1;
                        ex1_out_thread.cc_id = ex1.thread.cc_id + 1'b1;
                    end
                end
                MATCH_ANY:
                begin
                    ex1_out_valid        = 1'b1;
                    ex1_out_thread.cc_id = ex1.thread.cc_id + 1'b1;
                end
                JMP:
                begin
                    ex1_out_valid     = 1'b1;
                    ex1_out_thread.pc = ex1.instr.data.target;
                end
                SPLIT:
                begin
                    // pc+1 is offered only once exe2 is free to take the target
                    ex1_out_valid = !ex2_valid;
                    ex1_done      = 1'b0;
                end
                ACCEPT:
                begin
                    ex1_accepts = (window[ex1.thread.cc_id] == '0);
                end
                ACCEPT_PARTIAL:
                begin
                    ex1_accepts = 1'b1;
                end
                default:
                begin
                    ex1_done = 1'b1;
                end
            endcase
        end
    end

    // exe2 only ever holds a SPLIT
    assign ex2_out_valid        = ex2_valid;
    assign ex2_out_thread.pc    = ex2.instr.data.target;
    assign ex2_out_thread.cc_id = ex2.thread.cc_id;

    rr_arbiter #(
        .DWIDTH($bits(thread_t))
    ) u_out_arb (
        .clk        (clk),
        .rst        (rst),
        .in_0_valid (ex1_out_valid),
        .in_0_data  (ex1_out_thread),
        .in_0_ready (ex1_out_ready),
        .in_1_valid (ex2_out_valid),
        .in_1_data  (ex2_out_thread),
        .in_1_ready (ex2_out_ready),
        .out_valid  (out_valid),
        .out_data   (out_thread),
        .out_ready  (out_ready)
    );

    assign accepts = ex1_accepts;
    assign running = fr_valid || ex1_valid || ex2_valid;

endmodule

`default_nettype wire

// File: hw/regex_engine.sv
// regex engine top: thread start, feedback loop through the queue, match and done flags
`default_nettype none

module regex_engine (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             prog_we,
    input  logic [regex_pkg::PC_WIDTH-1:0]   prog_addr,
    input  regex_pkg::instr_t                prog_data,

    input  regex_pkg::window_t               window,
    input  logic                             start,

    output logic                             matched,
    output logic                             done
);

    import regex_pkg::*;

    logic                start_pending;
    logic                start_ready;
    logic                start_fire;
    thread_t             start_thread;

    logic                cpu_out_valid;
    logic                cpu_out_ready;
    thread_t             cpu_out_thread;

    logic                q_in_valid;
    logic                q_in_ready;
    thread_t             q_in_thread;
    logic                q_out_valid;
    logic                q_out_ready;
    thread_t             q_out_thread;
    logic                q_empty;

    logic                mem_valid;
    logic                mem_ready;
    logic [PC_WIDTH-1:0] mem_addr;
    instr_t              mem_data;

    logic                accepts;
    logic                running;

    // a new run always begins at pc 0 on the first character
    assign start_thread = '{pc: '0, cc_id: '0};
    assign start_fire   = start_pending && start_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start_pending <= 1'b0;
            matched       <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                start_pending <= 1'b1;
            end
            else if (start_fire)
            begin
                start_pending <= 1'b0;
            end
            if (start_fire)
            begin
                matched <= 1'b0;
            end
            else if (accepts)
            begin
                matched <= 1'b1;
            end
        end
    end

    assign done = q_empty && !running && !start_pending && !cpu_out_valid;

    rr_arbiter #(
        .DWIDTH($bits(thread_t))
    ) u_in_arb (
        .clk        (clk),
        .rst        (rst),
        .in_0_valid (cpu_out_valid),
        .in_0_data  (cpu_out_thread),
        .in_0_ready (cpu_out_ready),
        .in_1_valid (start_pending),
        .in_1_data  (start_thread),
        .in_1_ready (start_ready),
        .out_valid  (q_in_valid),
        .out_data   (q_in_thread),
        .out_ready  (q_in_ready)
    );

    thread_fifo u_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (q_in_valid),
        .in_thread  (q_in_thread),
        .in_ready   (q_in_ready),
        .out_valid  (q_out_valid),
        .out_thread (q_out_thread),
        .out_ready  (q_out_ready),
        .empty      (q_empty)
    );

    instr_mem u_mem (
        .clk        (clk),
        .we         (prog_we),
        .waddr      (prog_addr),
        .wdata      (prog_data),
        .req_valid  (mem_valid),
        .req_addr   (mem_addr),
        .req_ready  (mem_ready),
        .rdata      (mem_data)
    );

    regex_cpu_pipelined u_cpu (
        .clk        (clk),
        .rst        (rst),
        .window     (window),
        .in_valid   (q_out_valid),
        .in_thread  (q_out_thread),
        .in_ready   (q_out_ready),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_data   (mem_data),
        .out_valid  (cpu_out_valid),
        .out_thread (cpu_out_thread),
        .out_ready  (cpu_out_ready),
        .accepts    (accepts),
        .running    (running)
    );

endmodule

`default_nettype wire

// File: hw/regex_pkg.sv
// sizes, opcode encoding, instruction, thread and window types of the regex engine
`default_nettype none

package regex_pkg;

    localparam int PC_WIDTH     = 8;
    localparam int CHAR_WIDTH   = 8;
    localparam int CC_ID_BITS   = 2;
    localparam int WINDOW_CHARS = 4;
    localparam int THREAD_DEPTH = 8;

    typedef enum logic [2:0] {
        ACCEPT                = 3'd0,
        ACCEPT_PARTIAL        = 3'd1,
        SPLIT                 = 3'd2,
        MATCH                 = 3'd3,
        MATCH_ANY             = 3'd4,
        JMP                   = 3'd5,
        END_WITHOUT_ACCEPTING = 3'd6
    } opcode_t;

    // MATCH reads the data field as a character, JMP and SPLIT as a target pc
    typedef union packed {
        logic [CHAR_WIDTH-1:0] ch;
        logic [PC_WIDTH-1:0]   target;
    } instr_data_t;

    typedef struct packed {
        opcode_t     opcode;
        instr_data_t data;
    } instr_t;

    typedef struct packed {
        logic [PC_WIDTH-1:0]   pc;
        logic [CC_ID_BITS-1:0] cc_id;
    } thread_t;

    // character i of the window sits at window[i]
    typedef logic [WINDOW_CHARS-1:0][CHAR_WIDTH-1:0] window_t;

endpackage

`default_nettype wire

// File: hw/rr_arbiter.sv
// two-input round-robin arbiter for ready-valid streams
`default_nettype none

module rr_arbiter #(
    parameter int DWIDTH = 10
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              in_0_valid,
    input  logic [DWIDTH-1:0] in_0_data,
    output logic              in_0_ready,

    input  logic              in_1_valid,
    input  logic [DWIDTH-1:0] in_1_data,
    output logic              in_1_ready,

    output logic              out_valid,
    output logic [DWIDTH-1:0] out_data,
    input  logic              out_ready
);

    // high when input 1 won the last transfer
    logic last_1;
    logic grant_1;

    // input 1 wins when it is alone or when input 0 was served last
    assign grant_1 = in_1_valid && (!in_0_valid || !last_1);

    assign out_valid  = in_0_valid || in_1_valid;
    assign out_data   = grant_1 ? in_1_data : in_0_data;
    assign in_0_ready = out_ready && !grant_1;
    assign in_1_ready = out_ready && grant_1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_1 <= 1'b0;
        end
        else if (out_valid && out_ready)
        begin
            last_1 <= grant_1;
        end
    end

endmodule

`default_nettype wire

// File: hw/thread_fifo.sv
// circular queue of pending threads with ready-valid ports
`default_nettype none

module thread_fifo (
    input  logic               clk,
    input  logic               rst,

    input  logic               in_valid,
    input  regex_pkg::thread_t in_thread,
    output logic               in_ready,

    output logic               out_valid,
    output regex_pkg::thread_t out_thread,
    input  logic               out_ready,

    output logic               empty
);

    import regex_pkg::*;

    thread_t                             slots [THREAD_DEPTH];
    logic [$clog2(THREAD_DEPTH)-1:0]     rd_ptr;
    logic [$clog2(THREAD_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(THREAD_DEPTH+1)-1:0]   count;
    logic                                push;
    logic                                pop;

    assign in_ready   = (count != THREAD_DEPTH);
    assign out_valid  = (count != 0);
    assign empty      = (count == 0);
    assign out_thread = slots[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            slots[wr_ptr] <= in_thread;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_regex_engine \
    -o tb_regex_engine

output=$(./obj_dir/tb_regex_engine)
echo "$output"

# the run passes only if the testbench printed the pass message
echo "$output" | grep -q "^Test completed successfully$"

// File: tb.f
hw/regex_pkg.sv
hw/rr_arbiter.sv
hw/thread_fifo.sv
hw/instr_mem.sv
hw/regex_cpu_pipelined.sv
hw/regex_engine.sv
dv/tb_regex_engine.sv
